// File: hdl/rgmii_rx_params.svh
`ifndef RGMII_RX_PARAMS_SVH
`define RGMII_RX_PARAMS_SVH

// Frame buffer size in bytes
// One entry always stays free so that full differs from empty
`define RX_BUF_DEPTH 64
// Log2 of the buffer depth
`define RX_BUF_ADDR_W 6

// Width of the discarded frame counter
`define DROP_COUNT_W 8

// Data byte sent with error and no enable to flag a false carrier
`define FALSE_CARRIER_CODE 8'h0e

`endif

// File: hdl/rgmii_rx_pkg.sv
`include "rgmii_rx_params.svh"

package rgmii_rx_pkg;

	// One GMII byte and one RGMII nibble
	typedef logic [7:0] byte_t;
	typedef logic [3:0] nibble_t;

	// In-band speed code, carried on data bits 2:1 between frames
	typedef logic [1:0] link_speed_t;

	localparam link_speed_t link_10m   = 2'd0;
	localparam link_speed_t link_100m  = 2'd1;
	localparam link_speed_t link_1000m = 2'd2;

	// Frame buffer addressing and drop statistics
	typedef logic [`RX_BUF_ADDR_W-1:0] buf_addr_t;
	typedef logic [`DROP_COUNT_W-1:0]  drop_count_t;

	// Write side of the frame buffer
	typedef enum logic [1:0] {
		buf_idle,
		buf_storing,
		buf_discarding
	} buf_state_t;

endpackage

// File: hdl/rgmii_rx_decoder.sv
`timescale 1ns/1ns
`include "rgmii_rx_params.svh"

module rgmii_rx_decoder (
	input  logic                      gmii_rxc,
	input  logic                      arst_n,
	input  rgmii_rx_pkg::nibble_t     rxd_rise,
	input  rgmii_rx_pkg::nibble_t     rxd_fall,
	input  logic                      rx_ctl_rise,
	input  logic                      rx_ctl_fall,
	output logic                      rx_en,
	output logic                      rx_er,
	output logic                      rx_dvalid,
	output rgmii_rx_pkg::byte_t       rx_data,
	output logic                      link_up,
	output rgmii_rx_pkg::link_speed_t link_speed,
	output logic                      false_carrier
);

	// Split inputs after one register stage
	rgmii_rx_pkg::nibble_t rxd_rise_q;
	rgmii_rx_pkg::nibble_t rxd_fall_q;
	logic                  ctl_rise_q;
	logic                  ctl_fall_q;

	// Rising nibble of the cycle before as low half of a 10/100 byte
	rgmii_rx_pkg::nibble_t nib_lo_q;

	// Both halves of the cycle joined with the low nibble on the rising edge
	rgmii_rx_pkg::byte_t   ddr_byte;

	// Frame edge detect and 10/100 byte phase
	logic                  en_q;
	logic                  frame_start;
	logic                  phase_q;

	// Control halves differ on an error inside a frame or a special symbol between frames
	logic                  ctl_err;

	////////////////////////////////////////////////////////////////////////////
	// Input stage
	////////////////////////////////////////////////////////////////////////////

	// Data nibbles
	always_ff @(posedge gmii_rxc) begin
		rxd_rise_q <= rxd_rise;
		rxd_fall_q <= rxd_fall;
		// Keep the earlier rising nibble for the slow modes
		nib_lo_q   <= rxd_rise_q;
	end

	always_ff @(posedge gmii_rxc or negedge arst_n) begin
		if (!arst_n) begin
			ctl_rise_q <= 1'b0;
			ctl_fall_q <= 1'b0;
			en_q       <= 1'b0;
			phase_q    <= 1'b0;
		end else begin
			ctl_rise_q <= rx_ctl_rise;
			ctl_fall_q <= rx_ctl_fall;
			en_q       <= rx_en;
			// Lock the nibble phase at the start of every frame
			// First byte completes one cycle after the start
			if (frame_start) begin
				phase_q <= 1'b1;
			end else begin
				phase_q <= ~phase_q;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Control decode
	////////////////////////////////////////////////////////////////////////////

	// Enable is the rising control bit
	assign rx_en       = ctl_rise_q;
	// Falling bit carries enable xor error
	assign ctl_err     = ctl_rise_q ^ ctl_fall_q;
	assign rx_er       = ctl_err && rx_en;
	assign frame_start = rx_en && !en_q;
	assign ddr_byte    = {rxd_fall_q, rxd_rise_q};

	// Byte rebuild per link speed
	always_comb begin
		if (link_speed == rgmii_rx_pkg::link_1000m) begin
			// Full byte on every cycle of the frame
			rx_data   = ddr_byte;
			rx_dvalid = rx_en;
		end else begin
			// Nibble repeated on both edges
			// high nibble now, low nibble from the cycle before
			rx_data   = {rxd_rise_q, nib_lo_q};
			// Only a low nibble is held in the first cycle
			rx_dvalid = rx_en && !frame_start && phase_q;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// In-band status
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge gmii_rxc or negedge arst_n) begin
		if (!arst_n) begin
			link_up       <= 1'b0;
			link_speed    <= rgmii_rx_pkg::link_10m;
			false_carrier <= 1'b0;
		end else begin
			false_carrier <= 1'b0;
			if (!rx_en) begin
				if (!ctl_err) begin
					// Normal gap
					// bit 0 is link state, bits 2:1 the speed
					link_up    <= ddr_byte[0];
					link_speed <= ddr_byte[2:1];
				end else if (ddr_byte == `FALSE_CARRIER_CODE) begin
					// Error without enable leaves the link status as is
					false_carrier <= 1'b1;
				end
			end
		end
	end

	// At 10/100 a byte takes two cycles, so bytes never come back to back
	a_slow_dvalid_alternates: assert property (
		@(posedge gmii_rxc) disable iff (!arst_n)
		rx_dvalid && (link_speed != rgmii_rx_pkg::link_1000m) |=> !rx_dvalid
	);

endmodule

// File: hdl/rx_frame_buffer.sv
`timescale 1ns/1ns
`include "rgmii_rx_params.svh"

module rx_frame_buffer (
	input  logic                      gmii_rxc,
	input  logic                      arst_n,
	input  logic                      rx_en,
	input  logic                      rx_er,
	input  logic                      rx_dvalid,
	input  rgmii_rx_pkg::byte_t       rx_data,
	input  logic                      out_ready,
	output rgmii_rx_pkg::byte_t       out_data,
	output logic                      out_last,
	output logic                      out_valid,
	output rgmii_rx_pkg::drop_count_t drop_count
);

	// Entry holds the last flag above the data byte
	logic [8:0] mem [`RX_BUF_DEPTH];

	rgmii_rx_pkg::buf_state_t state_q;
	rgmii_rx_pkg::buf_state_t state_d;

	// Read, committed and write pointers in ring order
	rgmii_rx_pkg::buf_addr_t  rd_ptr;
	rgmii_rx_pkg::buf_addr_t  commit_ptr;
	rgmii_rx_pkg::buf_addr_t  wr_ptr;
	rgmii_rx_pkg::buf_addr_t  wr_ptr_inc;

	// Fill levels seen from the read pointer
	rgmii_rx_pkg::buf_addr_t  commit_fill;
	rgmii_rx_pkg::buf_addr_t  write_fill;

	// Byte waiting for its successor or the frame end
	rgmii_rx_pkg::byte_t      stage_q;
	logic                     stage_v_q;

	logic                     en_q;
	logic                     frame_end;
	logic                     push;
	logic                     full;
	logic                     wr_en;
	logic                     commit;
	logic                     drop;
	logic                     load;

	////////////////////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////////////////////

	assign frame_end  = en_q && !rx_en;
	assign wr_ptr_inc = wr_ptr + 1'b1;
	assign full       = (wr_ptr_inc == rd_ptr);
	// Staged byte moves on when the next byte or the frame end shows up
	assign push       = stage_v_q && (rx_dvalid || frame_end);
	assign wr_en      = (state_q == rgmii_rx_pkg::buf_storing) && push && !full;
	// Final byte written means the frame is clean
	assign commit     = wr_en && frame_end;
	assign drop       = frame_end && ((state_q == rgmii_rx_pkg::buf_discarding) ||
		((state_q == rgmii_rx_pkg::buf_storing) && push && full));

	always_comb begin
		state_d = state_q;
		case (state_q)
			rgmii_rx_pkg::buf_idle: begin
				if (rx_en) begin
					state_d = rx_er ? rgmii_rx_pkg::buf_discarding : rgmii_rx_pkg::buf_storing;
				end
			end
			rgmii_rx_pkg::buf_storing: begin
				if (frame_end) begin
					state_d = rgmii_rx_pkg::buf_idle;
				end else if (rx_er || (push && full)) begin
					// Bad or too long, the rest of the frame is thrown away
					state_d = rgmii_rx_pkg::buf_discarding;
				end
			end
			default: begin
				if (frame_end) begin
					state_d = rgmii_rx_pkg::buf_idle;
				end
			end
		endcase
	end

	always_ff @(posedge gmii_rxc or negedge arst_n) begin
		if (!arst_n) begin
			state_q    <= rgmii_rx_pkg::buf_idle;
			en_q       <= 1'b0;
			stage_v_q  <= 1'b0;
			wr_ptr     <= '0;
			commit_ptr <= '0;
			drop_count <= '0;
		end else begin
			state_q <= state_d;
			en_q    <= rx_en;
			if (frame_end || (state_d == rgmii_rx_pkg::buf_discarding)) begin
				stage_v_q <= 1'b0;
			end else if (rx_dvalid && (state_d == rgmii_rx_pkg::buf_storing)) begin
				stage_v_q <= 1'b1;
			end
			// Rewind to the last committed frame on a drop
			if (drop) begin
				wr_ptr <= commit_ptr;
			end else if (wr_en) begin
				wr_ptr <= wr_ptr_inc;
			end
			if (commit) begin
				commit_ptr <= wr_ptr_inc;
			end
			if (drop) begin
				drop_count <= drop_count + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////////////////////

	// Fetch when committed data waits and the output byte is free or leaving
	assign load = (rd_ptr != commit_ptr) && (!out_valid || out_ready);

	always_ff @(posedge gmii_rxc or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr    <= '0;
			out_valid <= 1'b0;
		end else if (load) begin
			rd_ptr    <= rd_ptr + 1'b1;
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// Memory and payload
	always_ff @(posedge gmii_rxc) begin
		if (rx_dvalid) begin
			stage_q <= rx_data;
		end
		if (wr_en) begin
			mem[wr_ptr] <= {frame_end, stage_q};
		end
		if (load) begin
			{out_last, out_data} <= mem[rd_ptr];
		end
	end

	assign commit_fill = commit_ptr - rd_ptr;
	assign write_fill  = wr_ptr - rd_ptr;

	// Held byte waits unchanged for the sink
	a_out_stable: assert property (
		@(posedge gmii_rxc) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last)
	);

	// Reader stays behind the committed data
	a_rd_behind_commit: assert property (
		@(posedge gmii_rxc) disable iff (!arst_n)
		commit_fill <= write_fill
	);

endmodule

// File: hdl/rgmii_rx_top.sv
`timescale 1ns/1ns

module rgmii_rx_top (
	input  logic                      gmii_rxc,
	input  logic                      arst_n,
	input  rgmii_rx_pkg::nibble_t     rxd_rise,
	input  rgmii_rx_pkg::nibble_t     rxd_fall,
	input  logic                      rx_ctl_rise,
	input  logic                      rx_ctl_fall,
	input  logic                      out_ready,
	output rgmii_rx_pkg::byte_t       out_data,
	output logic                      out_last,
	output logic                      out_valid,
	output logic                      link_up,
	output rgmii_rx_pkg::link_speed_t link_speed,
	output logic                      false_carrier,
	output rgmii_rx_pkg::drop_count_t drop_count
);

	// GMII side between decoder and buffer
	logic                rx_en;
	logic                rx_er;
	logic                rx_dvalid;
	rgmii_rx_pkg::byte_t rx_data;

	rgmii_rx_decoder u_decoder (
		.gmii_rxc      (gmii_rxc),
		.arst_n        (arst_n),
		.rxd_rise      (rxd_rise),
		.rxd_fall      (rxd_fall),
		.rx_ctl_rise   (rx_ctl_rise),
		.rx_ctl_fall   (rx_ctl_fall),
		.rx_en         (rx_en),
		.rx_er         (rx_er),
		.rx_dvalid     (rx_dvalid),
		.rx_data       (rx_data),
		.link_up       (link_up),
		.link_speed    (link_speed),
		.false_carrier (false_carrier)
	);

	// No back-pressure toward the decoder
	rx_frame_buffer u_buffer (
		.gmii_rxc   (gmii_rxc),
		.arst_n     (arst_n),
		.rx_en      (rx_en),
		.rx_er      (rx_er),
		.rx_dvalid  (rx_dvalid),
		.rx_data    (rx_data),
		.out_ready  (out_ready),
		.out_data   (out_data),
		.out_last   (out_last),
		.out_valid  (out_valid),
		.drop_count (drop_count)
	);

endmodule

// File: tests/tb_rgmii_rx.sv
`timescale 1ns/1ns
`include "rgmii_rx_params.svh"

module tb_rgmii_rx;

	// Idle gap after each frame that lets the frame end and drop count settle
	localparam int ifg         = 4;
	localparam int small_len   = (`RX_BUF_DEPTH - 4) / 3;
	localparam int big_len     = `RX_BUF_DEPTH * 5 / 8;
	localparam int late_len    = `RX_BUF_DEPTH / 2;
	localparam int total_bytes = 20 + 2 * 16 + 20 + 12 + 3 * small_len + big_len + late_len;
	localparam int test_count  = 6;
	// Random ready costs about two cycles per byte plus status and gaps per test
	localparam int cycle_limit = 8 * total_bytes + 100 * test_count;
	localparam rgmii_rx_pkg::byte_t fc_code = `FALSE_CARRIER_CODE;

	logic                        gmii_rxc = 1'b0;
	logic                        arst_n;
	rgmii_rx_pkg::nibble_t       rxd_rise;
	rgmii_rx_pkg::nibble_t       rxd_fall;
	logic                        rx_ctl_rise;
	logic                        rx_ctl_fall;
	logic                        out_ready;
	rgmii_rx_pkg::byte_t         out_data;
	logic                        out_last;
	logic                        out_valid;
	logic                        link_up;
	rgmii_rx_pkg::link_speed_t   link_speed;
	logic                        false_carrier;
	rgmii_rx_pkg::drop_count_t   drop_count;

	// Status nibble repeated on both edges between frames
	rgmii_rx_pkg::nibble_t       status_nib;
	logic [31:0]                 lfsr = 32'h754d;
	int                          cycles = 0;
	rgmii_rx_pkg::byte_t         payload[$];
	// Bytes and lengths of the frames that must come out, in order
	rgmii_rx_pkg::byte_t         expect_q[$];
	int                          expect_len[$];

	rgmii_rx_top dut (
		.gmii_rxc      (gmii_rxc),
		.arst_n        (arst_n),
		.rxd_rise      (rxd_rise),
		.rxd_fall      (rxd_fall),
		.rx_ctl_rise   (rx_ctl_rise),
		.rx_ctl_fall   (rx_ctl_fall),
		.out_ready     (out_ready),
		.out_data      (out_data),
		.out_last      (out_last),
		.out_valid     (out_valid),
		.link_up       (link_up),
		.link_speed    (link_speed),
		.false_carrier (false_carrier),
		.drop_count    (drop_count)
	);

	always #10 gmii_rxc = ~gmii_rxc;

	// Hung run guard
	always @(posedge gmii_rxc) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Random source and compare tasks
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic b;
		b    = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'h8020_0003;
		end
		return b;
	endfunction

	function automatic rgmii_rx_pkg::byte_t random_byte();
		rgmii_rx_pkg::byte_t b;
		for (int k = 0; k < 8; k++) begin
			b[k] = lfsr_bit();
		end
		return b;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAIL %s expected %0h actual %0h", name, exp, act);
		$display("TEST FAILED");
		$fatal(1, "wrong value in %s", name);
	endtask

	task automatic check_byte(input string name, input rgmii_rx_pkg::byte_t exp,
		input rgmii_rx_pkg::byte_t act);
		if (act !== exp) begin
			report_mismatch(name, 32'(exp), 32'(act));
		end
	endtask

	task automatic check_speed(input string name, input rgmii_rx_pkg::link_speed_t exp,
		input rgmii_rx_pkg::link_speed_t act);
		if (act !== exp) begin
			report_mismatch(name, 32'(exp), 32'(act));
		end
	endtask

	task automatic check_count(input string name, input rgmii_rx_pkg::drop_count_t exp,
		input rgmii_rx_pkg::drop_count_t act);
		if (act !== exp) begin
			report_mismatch(name, 32'(exp), 32'(act));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			report_mismatch(name, 32'(exp), 32'(act));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// RGMII drivers and stream receiver
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_idle(input int n);
		repeat (n) begin
			@(posedge gmii_rxc);
			rx_ctl_rise <= 1'b0;
			rx_ctl_fall <= 1'b0;
			rxd_rise    <= status_nib;
			rxd_fall    <= status_nib;
		end
	endtask

	// Bit 0 link state, bits 2:1 speed code
	task automatic send_status(input logic up, input rgmii_rx_pkg::link_speed_t spd);
		status_nib = {1'b0, spd, up};
		drive_idle(1);
	endtask

	task automatic new_frame(input int len);
		payload.delete();
		repeat (len) begin
			payload.push_back(random_byte());
		end
	endtask

	task automatic expect_frame();
		foreach (payload[i]) begin
			expect_q.push_back(payload[i]);
		end
		expect_len.push_back(payload.size());
	endtask

	// Gigabit frame, error shown on byte err_at (none if negative)
	task automatic send_gig(input int err_at);
		foreach (payload[i]) begin
			@(posedge gmii_rxc);
			rx_ctl_rise <= 1'b1;
			rx_ctl_fall <= (i != err_at);
			rxd_rise    <= payload[i][3:0];
			rxd_fall    <= payload[i][7:4];
		end
		drive_idle(ifg);
	endtask

	// 10/100 frame, low nibble first, each nibble on both edges
	task automatic send_slow();
		rgmii_rx_pkg::nibble_t nib;
		foreach (payload[i]) begin
			for (int h = 0; h < 2; h++) begin
				nib = (h == 1) ? payload[i][7:4] : payload[i][3:0];
				@(posedge gmii_rxc);
				rx_ctl_rise <= 1'b1;
				rx_ctl_fall <= 1'b1;
				rxd_rise    <= nib;
				rxd_fall    <= nib;
			end
		end
		drive_idle(ifg);
	endtask

	// Takes one expected frame off the queue with random or steady ready
	task automatic receive_frame(input string name, input logic rand_rdy);
		int len;
		int got;
		len = expect_len.pop_front();
		got = 0;
		while (got < len) begin
			@(posedge gmii_rxc);
			if (out_valid && out_ready) begin
				check_byte(name, expect_q.pop_front(), out_data);
				check_bit({name, " last"}, got == len - 1, out_last);
				got++;
			end
			out_ready <= rand_rdy ? lfsr_bit() : 1'b1;
		end
		out_ready <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic apply_status(input string name, input logic up,
		input rgmii_rx_pkg::link_speed_t spd);
		logic                      old_up;
		rgmii_rx_pkg::link_speed_t old_spd;
		old_up  = link_up;
		old_spd = link_speed;
		send_status(up, spd);
		// Still the old status one cycle later
		@(posedge gmii_rxc);
		@(negedge gmii_rxc);
		check_bit({name, " early link"}, old_up, link_up);
		check_speed({name, " early speed"}, old_spd, link_speed);
		@(negedge gmii_rxc);
		check_bit({name, " link"}, up, link_up);
		check_speed({name, " speed"}, spd, link_speed);
	endtask

	task automatic test_status();
		apply_status("status 1000M", 1'b1, rgmii_rx_pkg::link_1000m);
		apply_status("status 100M", 1'b1, rgmii_rx_pkg::link_100m);
		apply_status("status down", 1'b0, rgmii_rx_pkg::link_10m);
	endtask

	task automatic test_gigabit();
		send_status(1'b1, rgmii_rx_pkg::link_1000m);
		drive_idle(3);
		new_frame(20);
		expect_frame();
		send_gig(-1);
		receive_frame("gigabit frame", 1'b0);
		check_count("gigabit drops", '0, drop_count);
	endtask

	task automatic test_fast_ethernet();
		send_status(1'b1, rgmii_rx_pkg::link_100m);
		drive_idle(3);
		check_speed("100M speed", rgmii_rx_pkg::link_100m, link_speed);
		new_frame(16);
		expect_frame();
		send_slow();
		receive_frame("100M frame", 1'b0);
		send_status(1'b1, rgmii_rx_pkg::link_1000m);
		drive_idle(3);
	endtask

	task automatic test_error_frame();
		new_frame(20);
		send_gig(8);
		check_count("error frame drops", rgmii_rx_pkg::drop_count_t'(1), drop_count);
		new_frame(12);
		expect_frame();
		send_gig(-1);
		receive_frame("frame after error", 1'b0);
		@(negedge gmii_rxc);
		check_bit("error frame output", 1'b0, out_valid);
	endtask

	task automatic test_backpressure();
		// Three frames fit the buffer together
		repeat (3) begin
			new_frame(small_len);
			expect_frame();
			send_gig(-1);
		end
		repeat (3) begin
			receive_frame("back to back frame", 1'b1);
		end
		check_count("back to back drops", rgmii_rx_pkg::drop_count_t'(1), drop_count);
		// Second frame finds too little room behind the first
		new_frame(big_len);
		expect_frame();
		send_gig(-1);
		new_frame(late_len);
		send_gig(-1);
		check_count("overflow drops", rgmii_rx_pkg::drop_count_t'(2), drop_count);
		receive_frame("frame before overflow", 1'b1);
		@(negedge gmii_rxc);
		check_bit("overflow frame output", 1'b0, out_valid);
	endtask

	task automatic test_false_carrier();
		@(posedge gmii_rxc);
		rx_ctl_rise <= 1'b0;
		rx_ctl_fall <= 1'b1;
		rxd_rise    <= fc_code[3:0];
		rxd_fall    <= fc_code[7:4];
		drive_idle(1);
		@(negedge gmii_rxc);
		check_bit("false carrier early", 1'b0, false_carrier);
		@(negedge gmii_rxc);
		check_bit("false carrier pulse", 1'b1, false_carrier);
		check_bit("false carrier link", 1'b1, link_up);
		check_speed("false carrier speed", rgmii_rx_pkg::link_1000m, link_speed);
		@(negedge gmii_rxc);
		check_bit("false carrier end", 1'b0, false_carrier);
	endtask

	initial begin
		arst_n      = 1'b0;
		rxd_rise    = '0;
		rxd_fall    = '0;
		rx_ctl_rise = 1'b0;
		rx_ctl_fall = 1'b0;
		out_ready   = 1'b0;
		status_nib  = '0;
		repeat (2) @(posedge gmii_rxc);
		arst_n <= 1'b1;
		drive_idle(4);
		check_bit("reset out_valid", 1'b0, out_valid);
		check_bit("reset link_up", 1'b0, link_up);
		check_bit("reset false_carrier", 1'b0, false_carrier);
		check_speed("reset speed", rgmii_rx_pkg::link_10m, link_speed);
		check_count("reset drops", '0, drop_count);
		test_status();
		test_gigabit();
		test_fast_ethernet();
		test_error_frame();
		test_backpressure();
		test_false_carrier();
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: src.f
+incdir+hdl
hdl/rgmii_rx_pkg.sv
hdl/rgmii_rx_decoder.sv
hdl/rx_frame_buffer.sv
hdl/rgmii_rx_top.sv
tests/tb_rgmii_rx.sv

// File: Makefile
# Verilator build and run of the RGMII receive testbench

VERILATOR ?= verilator
TOP       ?= tb_rgmii_rx
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

# Sources come from the file list, the header is tracked as well
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

# Simulator binary, rebuilt only when a source changes
$(OBJ_DIR)/V%: $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
